//--- design/decode_pkg.sv
/*
 * Shared widths, opcodes and bundles for the RV32 decode stage.
 * Opcodes are plain 7-bit constants; system opcodes are not decoded.
 * fwd_t covers integer registers only, bit 0 is rs1 and bit 1 is rs2.
 */
package decode_pkg;

    //////////////////////////////////////////////////
    // vector types
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [1:0]  alu_sel_t;
    typedef logic [4:0]  lsu_op_t;   // {unsigned, size[1:0], store, load}
    typedef logic [1:0]  md_op_t;

    localparam int NUM_SRC = 2;       // rs1 and rs2

    //////////////////////////////////////////////////
    // opcodes and function fields
    localparam opcode_t OP_LUI      = 7'b0110111;
    localparam opcode_t OP_AUIPC    = 7'b0010111;
    localparam opcode_t OP_JAL      = 7'b1101111;
    localparam opcode_t OP_JALR     = 7'b1100111;
    localparam opcode_t OP_BRANCH   = 7'b1100011;
    localparam opcode_t OP_LOAD     = 7'b0000011;
    localparam opcode_t OP_STORE    = 7'b0100011;
    localparam opcode_t OP_FP_LOAD  = 7'b0000111;
    localparam opcode_t OP_FP_STORE = 7'b0100111;
    localparam opcode_t OP_IMM      = 7'b0010011;
    localparam opcode_t OP_ALU      = 7'b0110011;
    localparam opcode_t OP_IMM64    = 7'b0011011;
    localparam opcode_t OP_ALU64    = 7'b0111011;

    localparam funct7_t F7_MULDIV = 7'b0000001;
    localparam funct3_t F3_WORD   = 3'b010;    // lw/sw, also flw/fsw
    localparam funct3_t F3_DOUBLE = 3'b011;    // ld/sd, also fld/fsd

    localparam alu_sel_t ALU_SEL_RS   = 2'b00;
    localparam alu_sel_t ALU_SEL_PC   = 2'b01;
    localparam alu_sel_t ALU_SEL_IMM  = 2'b10;
    localparam alu_sel_t ALU_SEL_NONE = 2'b11;

    //////////////////////////////////////////////////
    // bundles
    typedef struct packed {
        inst_t inst;
        xlen_t pc;
        xlen_t pc_4;
    } fetch_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
    } wb_tag_t;

    typedef struct packed {
        logic [NUM_SRC-1:0] mem;   // hit against the ID/EX destination
        logic [NUM_SRC-1:0] wb;    // hit against the EX/MEM destination
    } fwd_t;

    typedef struct packed {
        logic     we;
        alu_sel_t alu_sel1;
        alu_sel_t alu_sel2;
        lsu_op_t  lsu_op;
        logic     mult_en;
        md_op_t   mult_op;
        logic     div_en;
        md_op_t   div_op;
        logic     branch;
        logic     jal;
        logic     jalr;
    } dec_ctrl_t;

    typedef struct packed {
        xlen_t      pc;
        opcode_t    opcode;
        funct3_t    funct3;
        funct7_t    funct7;
        reg_addr_t  rd;
        xlen_t      rs1_data;
        xlen_t      rs2_data;
        xlen_t      store_data;
        xlen_t      imm;
        logic [5:0] shamt;
        dec_ctrl_t  ctrl;
        fwd_t       fwd;
    } id_ex_t;

    // a bubble is all zero apart from the unused ALU sources
    localparam dec_ctrl_t CTRL_BUBBLE =
        '{alu_sel1: ALU_SEL_NONE, alu_sel2: ALU_SEL_NONE, default: '0};
    localparam id_ex_t ID_EX_BUBBLE = '{ctrl: CTRL_BUBBLE, default: '0};

endpackage

//--- design/inst_select.sv
/*
 * Instruction mux and register field extraction.
 * irq_ctrl high replaces the fetched word with the injected one,
 * the PC fields of fetch are not touched here.
 */
`timescale 1ns/100ps

module inst_select (
    input  decode_pkg::fetch_t    fetch,
    input  decode_pkg::inst_t     inst_inj,
    input  logic                  irq_ctrl,
    output decode_pkg::inst_t     inst,
    output decode_pkg::reg_addr_t rs1,
    output decode_pkg::reg_addr_t rs2,
    output decode_pkg::reg_addr_t rd,
    output logic                  rs1_rd_op,
    output logic                  rs2_rd_op
);
    import decode_pkg::*;

    opcode_t opcode;

    assign inst   = irq_ctrl ? inst_inj : fetch.inst;   // injected stream wins
    assign opcode = inst[6:0];

    always_comb begin
        rs1 = inst[19:15];
        rs2 = '0;
        rd  = inst[11:7];
        if (opcode inside {OP_LUI, OP_AUIPC, OP_JAL}) begin
            rs1 = '0;                                    // no rs1 field in U/J form
        end
        if (opcode inside {OP_BRANCH, OP_STORE}) begin
            rd = '0;                                     // bits 11:7 hold immediate
        end
        if (opcode inside {OP_BRANCH, OP_STORE, OP_ALU}) begin
            rs2 = inst[24:20];
        end
    end

    assign rs1_rd_op = opcode inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_FP_LOAD,
                                      OP_FP_STORE, OP_IMM, OP_ALU, OP_IMM64, OP_ALU64};
    assign rs2_rd_op = opcode inside {OP_BRANCH, OP_STORE, OP_ALU, OP_ALU64};

endmodule

//--- design/ctrl_decode.sv
/*
 * Control decode for write-back, ALU sources, load/store and mul/div.
 * Unknown opcodes, including system, give no write and RS/RS selects.
 * Reserved load/store widths decode as no access.
 */
`timescale 1ns/100ps

module ctrl_decode (
    input  decode_pkg::inst_t     inst,
    output decode_pkg::dec_ctrl_t ctrl
);
    import decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_muldiv;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign is_muldiv = (opcode == OP_ALU) && (funct7 == F7_MULDIV);

    always_comb begin
        ctrl = '0;

        //////////////////////////////////////////////////
        // register write-back
        ctrl.we = opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD,
                                 OP_IMM, OP_ALU, OP_IMM64, OP_ALU64};

        //////////////////////////////////////////////////
        // ALU operand sources
        case (opcode)
            OP_AUIPC, OP_JAL, OP_BRANCH: begin
                ctrl.alu_sel1 = ALU_SEL_IMM;            // target = imm + pc
                ctrl.alu_sel2 = ALU_SEL_PC;
            end
            OP_JALR, OP_LOAD, OP_STORE, OP_IMM, OP_FP_LOAD, OP_FP_STORE: begin
                ctrl.alu_sel1 = ALU_SEL_RS;
                ctrl.alu_sel2 = ALU_SEL_IMM;            // rs1 + offset
            end
            default: begin
                ctrl.alu_sel1 = ALU_SEL_RS;             // lui result comes from imm path
                ctrl.alu_sel2 = ALU_SEL_RS;
            end
        endcase

        //////////////////////////////////////////////////
        // load/store code, funct3 maps straight onto {unsigned, size}
        case (opcode)
            OP_LOAD: begin
                if (funct3 != 3'b111) begin
                    ctrl.lsu_op = {funct3, 2'b01};
                end
            end
            OP_STORE: begin
                if (!funct3[2]) begin
                    ctrl.lsu_op = {funct3, 2'b10};     // stores have no unsigned form
                end
            end
            OP_FP_LOAD: begin
                if (funct3 inside {F3_WORD, F3_DOUBLE}) begin
                    ctrl.lsu_op = {funct3, 2'b01};
                end
            end
            OP_FP_STORE: begin
                if (funct3 inside {F3_WORD, F3_DOUBLE}) begin
                    ctrl.lsu_op = {funct3, 2'b10};
                end
            end
            default: begin
                ctrl.lsu_op = '0;
            end
        endcase

        //////////////////////////////////////////////////
        // multiply/divide commands
        if (is_muldiv) begin
            if (!funct3[2]) begin
                ctrl.mult_en = 1'b1;
                ctrl.mult_op = {funct3[0], funct3[1]};  // mul 00, mulh 10, mulhsu 01, mulhu 11
                ctrl.div_op  = 2'b00;
            end else begin
                ctrl.div_en  = 1'b1;
                ctrl.div_op  = ~funct3[1:0];            // div 11, divu 10, rem 01, remu 00
                ctrl.mult_op = 2'b11;
            end
        end

        ctrl.branch = (opcode == OP_BRANCH);
        ctrl.jal    = (opcode == OP_JAL);
        ctrl.jalr   = (opcode == OP_JALR);
    end

endmodule

//--- design/imm_gen.sv
/*
 * Immediate generator for the RV32 formats.
 * Opcodes without an immediate, R-type included, give zero.
 */
`timescale 1ns/100ps

module imm_gen (
    input  decode_pkg::inst_t inst,
    output decode_pkg::xlen_t imm
);
    import decode_pkg::*;

    opcode_t opcode;
    xlen_t   imm_i;
    xlen_t   imm_s;
    xlen_t   imm_b;
    xlen_t   imm_u;
    xlen_t   imm_j;

    assign opcode = inst[6:0];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP_JAL:                               imm = imm_j;
            OP_JALR, OP_IMM, OP_LOAD, OP_FP_LOAD: imm = imm_i;
            OP_LUI, OP_AUIPC:                     imm = imm_u;
            OP_BRANCH:                            imm = imm_b;   // half-word aligned offset
            OP_STORE, OP_FP_STORE:                imm = imm_s;
            default:                              imm = '0;
        endcase
    end

endmodule

//--- design/fwd_detect.sv
/*
 * Integer forwarding detection against the ID/EX and EX/MEM stages.
 * x0 never forwards, and neither does a source the instruction does not read.
 * When both stages hit, both flags are set and EX picks the younger one.
 */
`timescale 1ns/100ps

module fwd_detect (
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  logic                  rs1_rd_op,
    input  logic                  rs2_rd_op,
    input  decode_pkg::wb_tag_t   ex_tag,
    input  decode_pkg::wb_tag_t   mem_tag,
    output decode_pkg::fwd_t      fwd
);
    import decode_pkg::*;

    reg_addr_t src    [NUM_SRC];
    logic      src_rd [NUM_SRC];

    function automatic logic tag_hit(input reg_addr_t r, input logic rd_op, input wb_tag_t tag);
        return rd_op && (r != '0) && tag.we && (tag.rd == r);
    endfunction

    assign src[0]    = rs1;
    assign src[1]    = rs2;
    assign src_rd[0] = rs1_rd_op;
    assign src_rd[1] = rs2_rd_op;

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            fwd.mem[i] = tag_hit(src[i], src_rd[i], ex_tag);    // result still in EX
            fwd.wb[i]  = tag_hit(src[i], src_rd[i], mem_tag);   // result in MEM
        end
    end

endmodule

//--- design/id_ex_reg.sv
/*
 * ID/EX pipeline register.
 * branch_taken, nop and md_stall load a bubble in place of the decoded
 * instruction, which is then lost, so fetch must replay it after a stall.
 */
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  branch_taken,
    input  logic                  nop,
    input  logic                  md_stall,
    input  decode_pkg::fetch_t    fetch,
    input  decode_pkg::inst_t     inst,
    input  decode_pkg::reg_addr_t rd,
    input  decode_pkg::dec_ctrl_t ctrl,
    input  decode_pkg::xlen_t     imm,
    input  decode_pkg::fwd_t      fwd,
    input  decode_pkg::xlen_t     rs1_data,
    input  decode_pkg::xlen_t     rs2_data,
    output decode_pkg::id_ex_t    id_ex
);
    import decode_pkg::*;

    logic   bubble;
    id_ex_t id_ex_d;

    assign bubble = branch_taken | nop | md_stall;

    always_comb begin
        id_ex_d.pc         = fetch.pc;
        id_ex_d.opcode     = inst[6:0];
        id_ex_d.funct3     = inst[14:12];
        id_ex_d.funct7     = inst[31:25];
        id_ex_d.rd         = rd;
        id_ex_d.rs1_data   = rs1_data;
        id_ex_d.rs2_data   = rs2_data;
        id_ex_d.store_data = (ctrl.jal || ctrl.jalr) ? fetch.pc_4 : rs2_data;  // link value
        id_ex_d.imm        = imm;
        id_ex_d.shamt      = {1'b0, inst[24:20]};
        id_ex_d.ctrl       = ctrl;
        id_ex_d.fwd        = fwd;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= ID_EX_BUBBLE;
        end else if (bubble) begin
            id_ex <= ID_EX_BUBBLE;                       // squash this slot
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

//--- design/decode_stage.sv
/*
 * Decode stage top level.
 * rs1_addr, rs2_addr and inst_out are combinational from fetch and inst_inj,
 * id_ex is registered with one cycle of latency.
 */
`timescale 1ns/100ps

module decode_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  decode_pkg::fetch_t    fetch,
    input  decode_pkg::inst_t     inst_inj,
    input  logic                  irq_ctrl,
    input  decode_pkg::xlen_t     rs1_data,
    input  decode_pkg::xlen_t     rs2_data,
    input  decode_pkg::wb_tag_t   ex_tag,
    input  decode_pkg::wb_tag_t   mem_tag,
    input  logic                  branch_taken,
    input  logic                  nop,
    input  logic                  md_stall,
    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr,
    output decode_pkg::inst_t     inst_out,
    output decode_pkg::id_ex_t    id_ex
);
    import decode_pkg::*;

    reg_addr_t rd;
    logic      rs1_rd_op;
    logic      rs2_rd_op;
    dec_ctrl_t ctrl;
    xlen_t     imm;
    fwd_t      fwd;

    inst_select u_inst_select (
        .fetch     (fetch),
        .inst_inj  (inst_inj),
        .irq_ctrl  (irq_ctrl),
        .inst      (inst_out),
        .rs1       (rs1_addr),
        .rs2       (rs2_addr),
        .rd        (rd),
        .rs1_rd_op (rs1_rd_op),
        .rs2_rd_op (rs2_rd_op)
    );

    ctrl_decode u_ctrl_decode (.inst(inst_out), .ctrl(ctrl));

    imm_gen u_imm_gen (.inst(inst_out), .imm(imm));

    fwd_detect u_fwd_detect (
        .rs1       (rs1_addr),
        .rs2       (rs2_addr),
        .rs1_rd_op (rs1_rd_op),
        .rs2_rd_op (rs2_rd_op),
        .ex_tag    (ex_tag),
        .mem_tag   (mem_tag),
        .fwd       (fwd)
    );

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_taken (branch_taken),
        .nop          (nop),
        .md_stall     (md_stall),
        .fetch        (fetch),
        .inst         (inst_out),
        .rd           (rd),
        .ctrl         (ctrl),
        .imm          (imm),
        .fwd          (fwd),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .id_ex        (id_ex)
    );

endmodule

//--- verif/decode_stage_tb.sv
/*
 * Self-checking testbench for decode_stage.
 * A reference model built from the decode rules predicts id_ex one cycle ahead.
 * Concurrent assertions compare it field by field at every rising edge.
 * Random instructions keep register fields in x0..x7 so hazards occur often.
 */
`timescale 1ns/100ps

module decode_stage_tb;
    import decode_pkg::*;

    localparam int DRAIN_LIMIT = 10;
    localparam int NUM_RANDOM  = 400;

    logic      clk = 1'b0;
    logic      arst_n;
    fetch_t    fetch;
    inst_t     inst_inj;
    logic      irq_ctrl;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    wb_tag_t   ex_tag;
    wb_tag_t   mem_tag;
    logic      branch_taken;
    logic      nop;
    logic      md_stall;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    inst_t     inst_out;
    id_ex_t    id_ex;

    int        seed   = 67;
    xlen_t     pc_cnt = 32'h0000_1000;
    inst_t     exp_inst;
    id_ex_t    exp_d;
    id_ex_t    exp_q;
    opcode_t   kept_ops [13] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                                 OP_STORE, OP_FP_LOAD, OP_FP_STORE, OP_IMM, OP_ALU,
                                 OP_IMM64, OP_ALU64};
    opcode_t   ls_ops [4] = '{OP_LOAD, OP_STORE, OP_FP_LOAD, OP_FP_STORE};

    decode_stage u_decode_stage (.*);

    always #10 clk = ~clk;                               // 20 ns period

    //////////////////////////////////////////////////
    // reference model
    function automatic reg_addr_t rs1_of(input inst_t i);
        if (i[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL}) return '0;
        return i[19:15];
    endfunction

    function automatic reg_addr_t rs2_of(input inst_t i);
        if (i[6:0] inside {OP_BRANCH, OP_STORE, OP_ALU}) return i[24:20];
        return '0;
    endfunction

    function automatic reg_addr_t rd_of(input inst_t i);
        if (i[6:0] inside {OP_BRANCH, OP_STORE}) return '0;
        return i[11:7];
    endfunction

    function automatic logic reads_rs1(input inst_t i);
        return i[6:0] inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_FP_LOAD,
                              OP_FP_STORE, OP_IMM, OP_ALU, OP_IMM64, OP_ALU64};
    endfunction

    function automatic logic reads_rs2(input inst_t i);
        return i[6:0] inside {OP_BRANCH, OP_STORE, OP_ALU, OP_ALU64};
    endfunction

    function automatic xlen_t imm_of(input inst_t i);
        case (i[6:0])
            OP_JAL:                               return $signed({i[31], i[19:12], i[20],
                                                                  i[30:21], 1'b0});
            OP_JALR, OP_IMM, OP_LOAD, OP_FP_LOAD: return $signed(i[31:20]);
            OP_LUI, OP_AUIPC:                     return {i[31:12], 12'h000};
            OP_BRANCH:                            return $signed({i[31], i[7], i[30:25],
                                                                  i[11:8], 1'b0});
            OP_STORE, OP_FP_STORE:                return $signed({i[31:25], i[11:7]});
            default:                              return '0;
        endcase
    endfunction

    function automatic dec_ctrl_t ctrl_of(input inst_t i);
        dec_ctrl_t c;
        opcode_t   op;
        funct3_t   f3;
        op = i[6:0];
        f3 = i[14:12];
        c  = '0;
        c.we = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_ALU,
                          OP_IMM64, OP_ALU64};
        if (op inside {OP_AUIPC, OP_JAL, OP_BRANCH}) begin
            c.alu_sel1 = ALU_SEL_IMM;
            c.alu_sel2 = ALU_SEL_PC;
        end else if (op inside {OP_JALR, OP_LOAD, OP_STORE, OP_IMM, OP_FP_LOAD,
                                OP_FP_STORE}) begin
            c.alu_sel2 = ALU_SEL_IMM;                    // sel1 stays RS
        end
        if (op == OP_LOAD && f3 != 3'b111) c.lsu_op = {f3[2], f3[1:0], 1'b0, 1'b1};
        if (op == OP_STORE && !f3[2]) c.lsu_op = {1'b0, f3[1:0], 1'b1, 1'b0};
        if (op == OP_FP_LOAD && f3 inside {3'b010, 3'b011}) c.lsu_op = {1'b0, f3[1:0], 2'b01};
        if (op == OP_FP_STORE && f3 inside {3'b010, 3'b011}) c.lsu_op = {1'b0, f3[1:0], 2'b10};
        if (op == OP_ALU && i[31:25] == F7_MULDIV) begin
            case (f3)                                    // {mult_en, mult_op, div_en, div_op}
                3'b000:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b1_00_0_00;
                3'b001:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b1_10_0_00;
                3'b010:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b1_01_0_00;
                3'b011:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b1_11_0_00;
                3'b100:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b0_11_1_11;
                3'b101:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b0_11_1_10;
                3'b110:  {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b0_11_1_01;
                default: {c.mult_en, c.mult_op, c.div_en, c.div_op} = 6'b0_11_1_00;
            endcase
        end
        c.branch = (op == OP_BRANCH);
        c.jal    = (op == OP_JAL);
        c.jalr   = (op == OP_JALR);
        return c;
    endfunction

    function automatic logic src_hit(input reg_addr_t r, input logic rd_op, input wb_tag_t t);
        return rd_op && r != 5'd0 && t.we && t.rd == r;
    endfunction

    function automatic id_ex_t build_id_ex(input inst_t i, input fetch_t f, input xlen_t d1,
                                           input xlen_t d2, input wb_tag_t ex,
                                           input wb_tag_t mem);
        id_ex_t e;
        e.pc         = f.pc;
        e.opcode     = i[6:0];
        e.funct3     = i[14:12];
        e.funct7     = i[31:25];
        e.rd         = rd_of(i);
        e.rs1_data   = d1;
        e.rs2_data   = d2;
        e.store_data = (i[6:0] inside {OP_JAL, OP_JALR}) ? f.pc_4 : d2;  // link address
        e.imm        = imm_of(i);
        e.shamt      = {1'b0, i[24:20]};
        e.ctrl       = ctrl_of(i);
        e.fwd.mem    = {src_hit(rs2_of(i), reads_rs2(i), ex),
                        src_hit(rs1_of(i), reads_rs1(i), ex)};
        e.fwd.wb     = {src_hit(rs2_of(i), reads_rs2(i), mem),
                        src_hit(rs1_of(i), reads_rs1(i), mem)};
        return e;
    endfunction

    function automatic id_ex_t make_bubble();
        id_ex_t b;
        b = '0;
        b.ctrl.alu_sel1 = ALU_SEL_NONE;
        b.ctrl.alu_sel2 = ALU_SEL_NONE;
        return b;
    endfunction

    assign exp_inst = irq_ctrl ? inst_inj : fetch.inst;
    assign exp_d    = build_id_ex(exp_inst, fetch, rs1_data, rs2_data, ex_tag, mem_tag);

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n || branch_taken || nop || md_stall) begin
            exp_q <= make_bubble();
        end else begin
            exp_q <= exp_d;
        end
    end

    //////////////////////////////////////////////////
    // checks
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        $display("Finished with errors");
        $fatal(1, "decode check failed");
    endtask

    a_inst: assert property (@(posedge clk) inst_out == exp_inst)
        else report_mismatch("inst_out", $sampled(exp_inst), $sampled(inst_out));
    a_rs1: assert property (@(posedge clk) rs1_addr == rs1_of(exp_inst))
        else report_mismatch("rs1_addr", rs1_of($sampled(exp_inst)), $sampled(rs1_addr));
    a_rs2: assert property (@(posedge clk) rs2_addr == rs2_of(exp_inst))
        else report_mismatch("rs2_addr", rs2_of($sampled(exp_inst)), $sampled(rs2_addr));
    a_pc: assert property (@(posedge clk) id_ex.pc == exp_q.pc)
        else report_mismatch("id_ex.pc", $sampled(exp_q.pc), $sampled(id_ex.pc));
    a_fields: assert property (@(posedge clk) {id_ex.opcode, id_ex.funct3, id_ex.funct7} ==
                                              {exp_q.opcode, exp_q.funct3, exp_q.funct7})
        else report_mismatch("id_ex.opcode/funct3/funct7",
                             $sampled({exp_q.opcode, exp_q.funct3, exp_q.funct7}),
                             $sampled({id_ex.opcode, id_ex.funct3, id_ex.funct7}));
    a_rd: assert property (@(posedge clk) id_ex.rd == exp_q.rd)
        else report_mismatch("id_ex.rd", $sampled(exp_q.rd), $sampled(id_ex.rd));
    a_d1: assert property (@(posedge clk) id_ex.rs1_data == exp_q.rs1_data)
        else report_mismatch("id_ex.rs1_data", $sampled(exp_q.rs1_data),
                             $sampled(id_ex.rs1_data));
    a_d2: assert property (@(posedge clk) id_ex.rs2_data == exp_q.rs2_data)
        else report_mismatch("id_ex.rs2_data", $sampled(exp_q.rs2_data),
                             $sampled(id_ex.rs2_data));
    a_sd: assert property (@(posedge clk) id_ex.store_data == exp_q.store_data)
        else report_mismatch("id_ex.store_data", $sampled(exp_q.store_data),
                             $sampled(id_ex.store_data));
    a_imm: assert property (@(posedge clk) id_ex.imm == exp_q.imm)
        else report_mismatch("id_ex.imm", $sampled(exp_q.imm), $sampled(id_ex.imm));
    a_shamt: assert property (@(posedge clk) id_ex.shamt == exp_q.shamt)
        else report_mismatch("id_ex.shamt", $sampled(exp_q.shamt), $sampled(id_ex.shamt));
    a_we: assert property (@(posedge clk) id_ex.ctrl.we == exp_q.ctrl.we)
        else report_mismatch("id_ex.ctrl.we", $sampled(exp_q.ctrl.we), $sampled(id_ex.ctrl.we));
    a_sel: assert property (@(posedge clk) {id_ex.ctrl.alu_sel1, id_ex.ctrl.alu_sel2} ==
                                           {exp_q.ctrl.alu_sel1, exp_q.ctrl.alu_sel2})
        else report_mismatch("id_ex.ctrl.alu_sel1/alu_sel2",
                             $sampled({exp_q.ctrl.alu_sel1, exp_q.ctrl.alu_sel2}),
                             $sampled({id_ex.ctrl.alu_sel1, id_ex.ctrl.alu_sel2}));
    a_lsu: assert property (@(posedge clk) id_ex.ctrl.lsu_op == exp_q.ctrl.lsu_op)
        else report_mismatch("id_ex.ctrl.lsu_op", $sampled(exp_q.ctrl.lsu_op),
                             $sampled(id_ex.ctrl.lsu_op));
    a_ctrl: assert property (@(posedge clk) id_ex.ctrl == exp_q.ctrl)
        else report_mismatch("id_ex.ctrl (mul/div, flags)", $sampled(exp_q.ctrl),
                             $sampled(id_ex.ctrl));
    a_fwd: assert property (@(posedge clk) id_ex.fwd == exp_q.fwd)
        else report_mismatch("id_ex.fwd", $sampled(exp_q.fwd), $sampled(id_ex.fwd));

    //////////////////////////////////////////////////
    // stimulus
    task automatic issue(input inst_t i, input logic irq, input logic [2:0] kill);
        logic [31:0] r;
        r = $random(seed);
        @(posedge clk);
        pc_cnt        = pc_cnt + 32'd4;
        fetch        <= '{inst: irq ? ~i : i, pc: pc_cnt, pc_4: pc_cnt + 32'd4};
        inst_inj     <= irq ? i : ~i;                    // the unused word differs
        irq_ctrl     <= irq;
        rs1_data     <= $random(seed);
        rs2_data     <= $random(seed);
        ex_tag       <= {r[0], 2'b00, r[3:1]};           // destinations in x0..x7
        mem_tag      <= {r[4], 2'b00, r[7:5]};
        {branch_taken, nop, md_stall} <= kill;
    endtask

    task automatic wait_for_pc(input xlen_t pc, input int limit);
        for (int n = 0; n < limit; n++) begin
            @(negedge clk);
            if (id_ex.pc == pc) return;
        end
        $display("Timeout: id_ex never showed the last instruction at pc %h", pc);
        $display("Finished with errors");
        $fatal(1, "drain timeout");
    endtask

    initial begin
        inst_t       rnd;
        logic [31:0] r;
        arst_n       = 1'b1;
        fetch        = '0;
        inst_inj     = '0;
        irq_ctrl     = 1'b0;
        rs1_data     = '0;
        rs2_data     = '0;
        ex_tag       = '0;
        mem_tag      = '0;
        branch_taken = 1'b0;
        nop          = 1'b0;
        md_stall     = 1'b0;
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        foreach (kept_ops[k]) begin                      // every format with both signs
            issue({25'h1A55C3B, kept_ops[k]}, 1'b0, 3'b000);
            issue({25'h05AA3C4, kept_ops[k]}, 1'b0, 3'b000);
        end
        foreach (ls_ops[k]) begin
            for (int f = 0; f < 8; f++) begin
                issue({7'h2A, 5'd5, 5'd2, funct3_t'(f), 5'd3, ls_ops[k]}, 1'b0, 3'b000);
            end
        end
        for (int f = 0; f < 8; f++) begin
            issue({F7_MULDIV, 5'd6, 5'd7, funct3_t'(f), 5'd1, OP_ALU}, 1'b0, 3'b000);
            issue({7'h00, 5'd6, 5'd7, funct3_t'(f), 5'd1, OP_ALU}, 1'b0, 3'b000);
        end
        issue(32'h0040_0093, 1'b1, 3'b000);              // injected addi
        issue(32'h0080_00EF, 1'b1, 3'b000);              // injected jal
        issue(32'h0000_8067, 1'b0, 3'b100);
        issue(32'h0000_8067, 1'b0, 3'b010);
        issue(32'h0000_8067, 1'b0, 3'b001);

        repeat (NUM_RANDOM) begin
            rnd        = $random(seed);
            rnd[6:0]   = kept_ops[$unsigned($random(seed)) % 13];
            rnd[19:18] = 2'b00;
            rnd[24:23] = 2'b00;
            r          = $random(seed);
            if (r[0]) rnd[31:25] = F7_MULDIV;
            issue(rnd, r[11:8] == 4'h0, (r[4:1] == 4'h0) ? r[7:5] : 3'b000);
        end

        issue(32'h0000_0013, 1'b0, 3'b000);              // plain nop marks the last slot
        wait_for_pc(pc_cnt, DRAIN_LIMIT);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- compile.f
design/decode_pkg.sv
design/inst_select.sv
design/ctrl_decode.sv
design/imm_gen.sv
design/fwd_detect.sv
design/id_ex_reg.sv
design/decode_stage.sv
verif/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - design/decode_pkg.sv
  - design/inst_select.sv
  - design/ctrl_decode.sv
  - design/imm_gen.sv
  - design/fwd_detect.sv
  - design/id_ex_reg.sv
  - design/decode_stage.sv
  - target: test
    files:
      - verif/decode_stage_tb.sv
